// File: logic/misc_regs_pkg.sv
package misc_regs_pkg;

	// **************************************************
	// Bus and register widths
	// **************************************************
	localparam int ADDR_W       = 6;
	localparam int DATA_W       = 32;
	localparam int NUM_EXT_REGS = 8;
	localparam int TICK_CFG_W   = 16;

	// Slot index width follows the register count
	localparam int EXT_IDX_W = $clog2(NUM_EXT_REGS);

	// Byte distance between two neighbouring external registers
	localparam int EXT_REG_STRIDE = 4;

	// **************************************************
	// Address map, offsets inside the peripheral window
	// **************************************************
	localparam logic [ADDR_W-1:0] ADDR_EXT_BASE = 6'h00;
	localparam logic [ADDR_W-1:0] ADDR_TICK_CFG = 6'h20;

	// Bytes covered by the external register bank
	localparam logic [ADDR_W-1:0] EXT_SPAN = ADDR_W'(NUM_EXT_REGS * EXT_REG_STRIDE);

	// **************************************************
	// Reset values
	// **************************************************
	localparam logic [DATA_W-1:0]     EXT_REG_DEFAULT  = 32'h0000_0000;
	localparam logic [TICK_CFG_W-1:0] TICK_CFG_DEFAULT = 16'h00FF;

	// **************************************************
	// Shared types
	// **************************************************

	// One APB request as seen by the decoder
	typedef struct packed {
		logic              sel;
		logic              enable;
		logic              write;
		logic [ADDR_W-1:0] addr;
		logic [DATA_W-1:0] wdata;
	} apb_req_t;

	// Read source, the slot number travels next to it
	typedef enum logic [1:0] {
		SEL_EXT,
		SEL_TICK,
		SEL_NONE
	} reg_sel_e;

endpackage

// File: logic/apb_misc_decoder.sv
module apb_misc_decoder
	import misc_regs_pkg::*;
(
	input  logic                    rvx_port_02,
	input  logic                    rvx_port_08,
	input  apb_req_t                req,
	output logic [NUM_EXT_REGS-1:0] ext_wr_en,
	output logic                    tick_wr_en,
	output reg_sel_e                rd_sel,
	output logic [EXT_IDX_W-1:0]    rd_idx,
	output logic                    slverr
);

	logic              aligned;
	logic [ADDR_W-1:0] ext_off;
	logic              ext_hit;
	logic              tick_hit;
	logic              wr_strobe;

	// **************************************************
	// Address decode
	// **************************************************
	always_comb
	begin
		// Only word accesses are accepted
		aligned = (req.addr[1:0] == 2'b00);

		// Offset into the bank, wraps high for addresses below the base
		ext_off  = req.addr - ADDR_EXT_BASE;
		ext_hit  = aligned && (ext_off < EXT_SPAN);
		tick_hit = aligned && (req.addr == ADDR_TICK_CFG);

		rd_idx = ext_off[2 +: EXT_IDX_W];
	end

	// Access phase of a write
	assign wr_strobe = req.sel && req.enable && req.write;

	always_comb
	begin
		ext_wr_en  = '0;
		tick_wr_en = 1'b0;
		rd_sel     = SEL_NONE;
		slverr     = 1'b0;

		if (req.sel)
		begin
			if (ext_hit)
			begin
				rd_sel    = SEL_EXT;
				ext_wr_en = wr_strobe ? (NUM_EXT_REGS'(1) << rd_idx) : '0;
			end
			else if (tick_hit)
			begin
				rd_sel     = SEL_TICK;
				tick_wr_en = wr_strobe;
			end
			else
			begin
				// Hole in the map or misaligned address
				slverr = 1'b1;
			end
		end
	end

	// At most one register in the whole block is written per cycle
	a_single_write: assert property (
		@(posedge rvx_port_02) disable iff (!rvx_port_08)
		$onehot0(ext_wr_en) && !(tick_wr_en && (|ext_wr_en))
	) else $error("decoder raised more than one write strobe");

endmodule

// File: logic/ext_reg_slot.sv
module ext_reg_slot
	import misc_regs_pkg::*;
(
	input  logic              rvx_port_02,
	input  logic              rvx_port_08,
	input  logic              wr_en,
	input  logic [DATA_W-1:0] wdata,
	output logic [DATA_W-1:0] value
);

	// One software visible word, also exported on the flat bus
	always_ff @(posedge rvx_port_02 or negedge rvx_port_08)
	begin
		if (!rvx_port_08)
		begin
			value <= EXT_REG_DEFAULT;
		end
		else if (wr_en)
		begin
			value <= wdata;
		end
	end

endmodule

// File: logic/misc_read_mux.sv
module misc_read_mux
	import misc_regs_pkg::*;
(
	input  reg_sel_e              rd_sel,
	input  logic [EXT_IDX_W-1:0]  rd_idx,
	input  logic [DATA_W-1:0]     slot_values [NUM_EXT_REGS],
	input  logic [TICK_CFG_W-1:0] tick_cfg,
	output logic [DATA_W-1:0]     rdata
);

	// **************************************************
	// Read data select
	// **************************************************
	always_comb
	begin
		rdata = '0;

		case (rd_sel)
			SEL_EXT:
			begin
				rdata = slot_values[rd_idx];
			end
			SEL_TICK:
			begin
				// Upper half reads as zero
				rdata = DATA_W'(tick_cfg);
			end
			default:
			begin
				rdata = '0;
			end
		endcase
	end

	// The decoder must never point past the last slot
	always_comb
	begin
		if (rd_sel == SEL_EXT)
		begin
			a_idx_range: assert (int'(rd_idx) < NUM_EXT_REGS)
				else $error("read index %0d outside the slot bank", rd_idx);
		end
	end

endmodule

// File: logic/gpio_tick_gen.sv
module gpio_tick_gen
	import misc_regs_pkg::*;
(
	input  logic                  rvx_port_02,
	input  logic                  rvx_port_08,
	input  logic                  cfg_wr_en,
	input  logic [DATA_W-1:0]     wdata,
	output logic [TICK_CFG_W-1:0] tick_cfg,
	output logic                  gpio_tick
);

	logic [TICK_CFG_W-1:0] cnt;
	logic                  cnt_hit;

	// Configuration register, only the low half of the bus word is kept
	always_ff @(posedge rvx_port_02 or negedge rvx_port_08)
	begin
		if (!rvx_port_08)
		begin
			tick_cfg <= TICK_CFG_DEFAULT;
		end
		else if (cfg_wr_en)
		begin
			tick_cfg <= wdata[TICK_CFG_W-1:0];
		end
	end

	assign cnt_hit = (cnt == tick_cfg);

	// **************************************************
	// Period counter and tick pulse
	// **************************************************
	always_ff @(posedge rvx_port_02 or negedge rvx_port_08)
	begin
		if (!rvx_port_08)
		begin
			cnt       <= '0;
			gpio_tick <= 1'b0;
		end
		else if (cfg_wr_en)
		begin
			// New period starts from the write edge
			cnt       <= '0;
			gpio_tick <= 1'b0;
		end
		else if (cnt_hit)
		begin
			cnt       <= '0;
			gpio_tick <= 1'b1;
		end
		else
		begin
			cnt       <= cnt + 1'b1;
			gpio_tick <= 1'b0;
		end
	end

	// Back to back pulses are only legal with a zero period setting
	a_tick_width: assert property (
		@(posedge rvx_port_02) disable iff (!rvx_port_08)
		gpio_tick |=> (!gpio_tick || (tick_cfg == '0))
	) else $error("gpio_tick held high with tick_cfg %0d", tick_cfg);

endmodule

// File: logic/misc_periph_top.sv
module misc_periph_top
	import misc_regs_pkg::*;
(
	input  logic                           rvx_port_02,
	input  logic                           rvx_port_08,

	// APB slave
	input  logic                           psel,
	input  logic                           penable,
	input  logic                           pwrite,
	input  logic [ADDR_W-1:0]              paddr,
	input  logic [DATA_W-1:0]              pwdata,
	output logic [DATA_W-1:0]              prdata,
	output logic                           pready,
	output logic                           pslverr,

	// Register values for the surrounding logic
	output logic [DATA_W*NUM_EXT_REGS-1:0] ext_regs,
	output logic [TICK_CFG_W-1:0]          tick_cfg,
	output logic                           gpio_tick
);

	apb_req_t              req;
	logic [NUM_EXT_REGS-1:0] ext_wr_en;
	logic                  tick_wr_en;
	reg_sel_e              rd_sel;
	logic [EXT_IDX_W-1:0]  rd_idx;
	logic [DATA_W-1:0]     slot_values [NUM_EXT_REGS];

	// Gather the APB inputs into one request
	assign req.sel    = psel;
	assign req.enable = penable;
	assign req.write  = pwrite;
	assign req.addr   = paddr;
	assign req.wdata  = pwdata;

	// No wait states
	assign pready = 1'b1;

	// **************************************************
	// Decode
	// **************************************************
	apb_misc_decoder apb_misc_decoder_inst (
		.rvx_port_02 (rvx_port_02),
		.rvx_port_08 (rvx_port_08),
		.req         (req),
		.ext_wr_en   (ext_wr_en),
		.tick_wr_en  (tick_wr_en),
		.rd_sel      (rd_sel),
		.rd_idx      (rd_idx),
		.slverr      (pslverr)
	);

	// **************************************************
	// External register bank
	// **************************************************
	for (genvar i = 0; i < NUM_EXT_REGS; i++)
	begin : g_slot
		ext_reg_slot ext_reg_slot_inst (
			.rvx_port_02 (rvx_port_02),
			.rvx_port_08 (rvx_port_08),
			.wr_en       (ext_wr_en[i]),
			.wdata       (req.wdata),
			.value       (slot_values[i])
		);

		// Slot i sits in lane i of the flat bus
		assign ext_regs[DATA_W*i +: DATA_W] = slot_values[i];
	end

	// **************************************************
	// Read back and tick generator
	// **************************************************
	misc_read_mux misc_read_mux_inst (
		.rd_sel      (rd_sel),
		.rd_idx      (rd_idx),
		.slot_values (slot_values),
		.tick_cfg    (tick_cfg),
		.rdata       (prdata)
	);

	gpio_tick_gen gpio_tick_gen_inst (
		.rvx_port_02 (rvx_port_02),
		.rvx_port_08 (rvx_port_08),
		.cfg_wr_en   (tick_wr_en),
		.wdata       (req.wdata),
		.tick_cfg    (tick_cfg),
		.gpio_tick   (gpio_tick)
	);

endmodule

// File: dv/misc_periph_tb.sv
module misc_periph_tb
	import misc_regs_pkg::*;
();

	localparam int          CLK_PERIOD      = 100;
	localparam logic [31:0] SEED            = 32'h82f2ce23;
	localparam int          TICK_TIMEOUT    = 40;
	localparam int          TICK_PULSES     = 4;
	localparam int          WATCHDOG_CYCLES = 5000;

	logic                           rvx_port_02;
	logic                           rvx_port_08;
	logic                           psel;
	logic                           penable;
	logic                           pwrite;
	logic [ADDR_W-1:0]              paddr;
	logic [DATA_W-1:0]              pwdata;
	logic [DATA_W-1:0]              prdata;
	logic                           pready;
	logic                           pslverr;
	logic [DATA_W*NUM_EXT_REGS-1:0] ext_regs;
	logic [TICK_CFG_W-1:0]          tick_cfg;
	logic                           gpio_tick;

	// Scoreboard, follows every write issued below
	logic [DATA_W*NUM_EXT_REGS-1:0] exp_ext_flat;
	logic [TICK_CFG_W-1:0]          exp_tick;
	int                             err_cnt;

	misc_periph_top misc_periph_top_inst (
		.rvx_port_02 (rvx_port_02),
		.rvx_port_08 (rvx_port_08),
		.psel        (psel),
		.penable     (penable),
		.pwrite      (pwrite),
		.paddr       (paddr),
		.pwdata      (pwdata),
		.prdata      (prdata),
		.pready      (pready),
		.pslverr     (pslverr),
		.ext_regs    (ext_regs),
		.tick_cfg    (tick_cfg),
		.gpio_tick   (gpio_tick)
	);

	initial
	begin
		rvx_port_02 = 1'b0;
		forever
		begin
			#(CLK_PERIOD / 2) rvx_port_02 = ~rvx_port_02;
		end
	end

	// **************************************************
	// Bus level checks
	// **************************************************
	a_ext_mirror: assert property (@(posedge rvx_port_02) disable iff (!rvx_port_08)
		ext_regs == exp_ext_flat)
	else
	begin
		err_cnt++;
		$display("Error ext_regs_mirror expected %h actual %h",
			$sampled(exp_ext_flat), $sampled(ext_regs));
	end

	a_tick_mirror: assert property (@(posedge rvx_port_02) disable iff (!rvx_port_08)
		tick_cfg == exp_tick)
	else
	begin
		err_cnt++;
		$display("Error tick_cfg_mirror expected %h actual %h",
			$sampled(exp_tick), $sampled(tick_cfg));
	end

	a_pready_high: assert property (@(posedge rvx_port_02) pready == 1'b1)
	else
	begin
		err_cnt++;
		$display("Error pready_high expected 1 actual %b", $sampled(pready));
	end

	// An error response never carries data
	a_err_no_data: assert property (@(posedge rvx_port_02) disable iff (!rvx_port_08)
		pslverr |-> (prdata == '0))
	else
	begin
		err_cnt++;
		$display("Error slverr_rdata expected 0 actual %h", $sampled(prdata));
	end

	a_idle_no_err: assert property (@(posedge rvx_port_02) disable iff (!rvx_port_08)
		!psel |-> !pslverr)
	else
	begin
		err_cnt++;
		$display("pslverr was raised while psel was low");
	end

	// **************************************************
	// Helpers
	// **************************************************
	task automatic check_value(input string name, input logic [31:0] exp,
		input logic [31:0] act);
		a_value: assert (act === exp)
		else
		begin
			err_cnt++;
			$display("Error %s expected %h actual %h", name, exp, act);
		end
	endtask

	// Register map as software sees it
	function automatic void model_write(input logic [ADDR_W-1:0] addr,
		input logic [DATA_W-1:0] data);
		int slot;
		slot = (int'(addr) - int'(ADDR_EXT_BASE)) / 4;
		if (addr[1:0] == 2'b00 && slot >= 0 && slot < NUM_EXT_REGS)
		begin
			exp_ext_flat[DATA_W*slot +: DATA_W] = data;
		end
		else if (addr == ADDR_TICK_CFG)
		begin
			exp_tick = data[TICK_CFG_W-1:0];
		end
	endfunction

	task automatic apb_write(input logic [ADDR_W-1:0] addr, input logic [DATA_W-1:0] data,
		output logic err);
		@(negedge rvx_port_02);
		psel    = 1'b1;
		penable = 1'b0;
		pwrite  = 1'b1;
		paddr   = addr;
		pwdata  = data;
		@(negedge rvx_port_02);
		penable = 1'b1;
		// Write edge closes the access phase
		@(posedge rvx_port_02);
		err = pslverr;
		@(negedge rvx_port_02);
		psel    = 1'b0;
		penable = 1'b0;
		pwrite  = 1'b0;
		model_write(addr, data);
	endtask

	task automatic apb_read(input logic [ADDR_W-1:0] addr, output logic [DATA_W-1:0] data,
		output logic err);
		@(negedge rvx_port_02);
		psel    = 1'b1;
		penable = 1'b0;
		pwrite  = 1'b0;
		paddr   = addr;
		@(negedge rvx_port_02);
		penable = 1'b1;
		@(posedge rvx_port_02);
		data = prdata;
		err  = pslverr;
		@(negedge rvx_port_02);
		psel    = 1'b0;
		penable = 1'b0;
	endtask

	task automatic wait_tick(inout int m);
		int waited;
		waited = 0;
		do
		begin
			@(negedge rvx_port_02);
			m++;
			waited++;
		end
		while (!gpio_tick && waited < TICK_TIMEOUT);
		if (!gpio_tick)
		begin
			$display("Timed out after %0d cycles waiting for gpio_tick", waited);
			$display("Errors found");
			$finish;
		end
	endtask

	// **************************************************
	// Tests
	// **************************************************
	task automatic read_reset_defaults();
		logic [DATA_W-1:0] rdata;
		logic              err;
		for (int i = 0; i < NUM_EXT_REGS; i++)
		begin
			apb_read(ADDR_W'(4 * i), rdata, err);
			check_value("reset_ext_err", 32'h0, 32'(err));
			check_value("reset_ext_read", 32'h0, rdata);
			check_value("reset_ext_lane", 32'h0, ext_regs[DATA_W*i +: DATA_W]);
		end
		apb_read(ADDR_TICK_CFG, rdata, err);
		check_value("reset_tick_err", 32'h0, 32'(err));
		check_value("reset_tick_read", 32'h0000_00FF, rdata);
		check_value("reset_tick_cfg", 32'h0000_00FF, 32'(tick_cfg));
	endtask

	task automatic write_ext_regs();
		logic [DATA_W-1:0] data;
		logic [DATA_W-1:0] rdata;
		logic [ADDR_W-1:0] addr;
		logic              err;
		for (int i = 0; i < NUM_EXT_REGS; i++)
		begin
			data = $urandom();
			addr = ADDR_EXT_BASE + ADDR_W'(4 * i);
			apb_write(addr, data, err);
			check_value("ext_write_err", 32'h0, 32'(err));
			check_value("ext_lane", data, ext_regs[DATA_W*i +: DATA_W]);
			apb_read(addr, rdata, err);
			check_value("ext_read_err", 32'h0, 32'(err));
			check_value("ext_readback", data, rdata);
		end
	endtask

	task automatic store_tick_cfg();
		logic [DATA_W-1:0] data;
		logic [DATA_W-1:0] rdata;
		logic              err;
		data = $urandom();
		apb_write(ADDR_TICK_CFG, data, err);
		check_value("tick_write_err", 32'h0, 32'(err));
		check_value("tick_cfg_port", {16'h0, data[15:0]}, 32'(tick_cfg));
		apb_read(ADDR_TICK_CFG, rdata, err);
		check_value("tick_read_err", 32'h0, 32'(err));
		check_value("tick_readback", {16'h0, data[15:0]}, rdata);
	endtask

	task automatic probe_bad_addresses();
		logic [ADDR_W-1:0] bad_addr [$];
		logic [DATA_W-1:0] rdata;
		logic              err;
		// Holes above the tick register
		for (int a = 'h24; a <= 'h3C; a += 4)
		begin
			bad_addr.push_back(ADDR_W'(a));
		end
		// Misaligned, inside and outside the map
		bad_addr.push_back(6'h01);
		bad_addr.push_back(6'h02);
		bad_addr.push_back(6'h03);
		bad_addr.push_back(6'h1E);
		bad_addr.push_back(6'h21);
		bad_addr.push_back(6'h3F);
		foreach (bad_addr[k])
		begin
			apb_read(bad_addr[k], rdata, err);
			check_value("bad_read_err", 32'h1, 32'(err));
			check_value("bad_read_data", 32'h0, rdata);
			apb_write(bad_addr[k], $urandom(), err);
			check_value("bad_write_err", 32'h1, 32'(err));
		end
		// Every register still holds what was written before
		for (int i = 0; i < NUM_EXT_REGS; i++)
		begin
			apb_read(ADDR_W'(4 * i), rdata, err);
			check_value("bad_keep_err", 32'h0, 32'(err));
			check_value("bad_keep_ext", exp_ext_flat[DATA_W*i +: DATA_W], rdata);
		end
		apb_read(ADDR_TICK_CFG, rdata, err);
		check_value("bad_keep_tick", {16'h0, exp_tick}, rdata);
	endtask

	task automatic measure_tick_period(input logic [TICK_CFG_W-1:0] n);
		logic err;
		int   m;
		apb_write(ADDR_TICK_CFG, DATA_W'(n), err);
		check_value("tick_period_err", 32'h0, 32'(err));
		// Counter restarts on the write edge
		check_value("tick_after_write", 32'h0, 32'(gpio_tick));
		m = 0;
		for (int p = 1; p <= TICK_PULSES; p++)
		begin
			wait_tick(m);
			check_value("tick_period", p * (int'(n) + 1), m);
			if (n != 0)
			begin
				@(negedge rvx_port_02);
				m++;
				check_value("tick_width", 32'h0, 32'(gpio_tick));
			end
		end
	endtask

	// **************************************************
	// Main sequence
	// **************************************************
	initial
	begin
		void'($urandom(SEED));
		psel         = 1'b0;
		penable      = 1'b0;
		pwrite       = 1'b0;
		paddr        = '0;
		pwdata       = '0;
		rvx_port_08  = 1'b0;
		err_cnt      = 0;
		exp_ext_flat = '0;
		exp_tick     = 16'h00FF;

		repeat (3) @(negedge rvx_port_02);
		rvx_port_08 = 1'b1;

		read_reset_defaults();
		write_ext_regs();
		store_tick_cfg();
		probe_bad_addresses();
		measure_tick_period(16'd0);
		for (int r = 0; r < 4; r++)
		begin
			measure_tick_period(TICK_CFG_W'($urandom_range(15, 0)));
		end

		$display("Checks finished with %0d errors", err_cnt);
		if (err_cnt == 0)
		begin
			$display("No errors");
		end
		else
		begin
			$display("Errors found");
		end
		$finish;
	end

	// Upper bound on the whole run
	initial
	begin
		repeat (WATCHDOG_CYCLES) @(posedge rvx_port_02);
		$display("Run stopped by the watchdog after %0d cycles", WATCHDOG_CYCLES);
		$display("Errors found");
		$finish;
	end

endmodule

// File: flist.f
logic/misc_regs_pkg.sv
logic/apb_misc_decoder.sv
logic/ext_reg_slot.sv
logic/misc_read_mux.sv
logic/gpio_tick_gen.sv
logic/misc_periph_top.sv
dv/misc_periph_tb.sv

// File: Makefile
# Verilator build and run for the miscellaneous peripheral block

VERILATOR ?= verilator
TOP       ?= misc_periph_tb
FLIST     ?= flist.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert
LINTFLAGS ?= --lint-only --timing

SOURCES := $(wildcard logic/*.sv dv/*.sv)

.PHONY: all build run lint clean

all: run

build: $(OBJ_DIR)/V$(TOP)

$(OBJ_DIR)/V$(TOP): $(FLIST) $(SOURCES)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FLIST)

run: build
	./$(OBJ_DIR)/V$(TOP) > $(LOG) 2>&1 || true
	@cat $(LOG)
	@if grep -q "Errors found" $(LOG); then echo "Simulation failed"; exit 1; fi
	@if ! grep -q "No errors" $(LOG); then echo "Simulation ended early"; exit 1; fi
	@echo "Simulation passed"

lint:
	$(VERILATOR) $(LINTFLAGS) --top-module $(TOP) -f $(FLIST)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
